// ==== common/cellnet_consts.svh ====
`ifndef CELLNET_CONSTS_SVH
`define CELLNET_CONSTS_SVH

// Cell field widths
`define DATA_SIZE 4
`define ADDRESS_SIZE 4

// Clock cycles between enable ticks
`define SRC_TICK_PERIOD 4
`define SNK_TICK_PERIOD 7

// Address the sink answers to
`define SINK_ADDR 4'h5

// Stable cycles before the button output follows the input
`define DEBOUNCE_LIMIT 8

`endif

// ==== common/cellnet_pkg.sv ====
`default_nettype none

`include "cellnet_consts.svh"

package cellnet_pkg;

	typedef logic [`ADDRESS_SIZE-1:0] addr_t;
	typedef logic [`DATA_SIZE-1:0] data_t;

	// Source side of the four-phase handshake
	typedef enum logic [1:0] {
		SRC_REQ,
		SRC_WAIT_ACK,
		SRC_WAIT_RELEASE
	} src_state_t;

	// Sink side
	typedef enum logic {
		SNK_WAIT_REQ,
		SNK_WAIT_RELEASE
	} snk_state_t;

endpackage

`default_nettype wire

// ==== common/disp_pkg.sv ====
`default_nettype none

package disp_pkg;

	// Segment A in bit 0 up to segment G in bit 6
	typedef logic [6:0] seg7_t;

	typedef logic [3:0] digit_t;

endpackage

`default_nettype wire

// ==== cellnet/cellnet_source.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cellnet_consts.svh"

module cellnet_source (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_tick,
	input  logic               i_ack,
	output logic               o_req,
	output cellnet_pkg::addr_t o_addr,
	output cellnet_pkg::data_t o_dat
);

	import cellnet_pkg::*;

	localparam int CNT_W = `ADDRESS_SIZE + `DATA_SIZE;

	src_state_t state;
	logic [CNT_W-1:0] cell_cnt;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= SRC_REQ;
			o_req <= 1'b0;
			cell_cnt <= '0;
		end else if (i_tick) begin
			case (state)
				SRC_REQ: begin
					// Addr and data already stable from the counter
					o_req <= 1'b1;
					state <= SRC_WAIT_ACK;
				end
				SRC_WAIT_ACK: begin
					if (i_ack) begin
						o_req <= 1'b0;
						state <= SRC_WAIT_RELEASE;
					end
				end
				SRC_WAIT_RELEASE: begin
					// Cell done once ack drops
					if (!i_ack) begin
						cell_cnt <= cell_cnt + 1'b1;
						state <= SRC_REQ;
					end
				end
				default: begin
					o_req <= 1'b0;
					state <= SRC_REQ;
				end
			endcase
		end
	end

	// Low nibble addresses, high nibble is payload
	assign o_addr = cell_cnt[`ADDRESS_SIZE-1:0];
	assign o_dat = cell_cnt[CNT_W-1:`ADDRESS_SIZE];

endmodule

`default_nettype wire

// ==== cellnet/cellnet_sink.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cellnet_consts.svh"

module cellnet_sink (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_tick,
	input  logic               i_req,
	input  cellnet_pkg::addr_t i_addr,
	input  cellnet_pkg::data_t i_dat,
	output logic               o_ack,
	output cellnet_pkg::data_t o_dat,
	output logic               o_err
);

	import cellnet_pkg::*;

	snk_state_t state;
	data_t expected;
	logic own_cell;

	assign own_cell = (i_addr == `SINK_ADDR);

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= SNK_WAIT_REQ;
			o_ack <= 1'b0;
			o_dat <= '0;
			o_err <= 1'b0;
			expected <= '0;
		end else begin
			// Error is a single-cycle pulse
			o_err <= 1'b0;
			if (i_tick) begin
				case (state)
					SNK_WAIT_REQ: begin
						if (i_req) begin
							o_ack <= 1'b1;
							state <= SNK_WAIT_RELEASE;
							if (own_cell) begin
								o_dat <= i_dat;
								o_err <= (i_dat != expected);
								expected <= expected + 1'b1;
							end
						end
					end
					SNK_WAIT_RELEASE: begin
						if (!i_req) begin
							o_ack <= 1'b0;
							state <= SNK_WAIT_REQ;
						end
					end
					default: begin
						o_ack <= 1'b0;
						state <= SNK_WAIT_REQ;
					end
				endcase
			end
		end
	end

	// Every cell gets an ack, only own-address cells
	// move the expected sequence on

endmodule

`default_nettype wire

// ==== verilog/link_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cellnet_consts.svh"

module link_tick_gen (
	input  logic i_clk,
	input  logic i_reset,
	output logic o_src_tick,
	output logic o_snk_tick
);

	logic [`SRC_TICK_PERIOD-1:0] src_ring;
	logic [`SNK_TICK_PERIOD-1:0] snk_ring;

	// Tick when the set bit wraps back to bit 0
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			src_ring <= `SRC_TICK_PERIOD'(1);
			snk_ring <= `SNK_TICK_PERIOD'(1);
			o_src_tick <= 1'b0;
			o_snk_tick <= 1'b0;
		end else begin
			src_ring <= {src_ring[`SRC_TICK_PERIOD-2:0], src_ring[`SRC_TICK_PERIOD-1]};
			snk_ring <= {snk_ring[`SNK_TICK_PERIOD-2:0], snk_ring[`SNK_TICK_PERIOD-1]};
			o_src_tick <= src_ring[`SRC_TICK_PERIOD-1];
			o_snk_tick <= snk_ring[`SNK_TICK_PERIOD-1];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cellnet_consts.svh"

module debounce (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_switch,
	output logic o_switch
);

	localparam int CNT_W = $clog2(`DEBOUNCE_LIMIT + 1);

	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			stable_cnt <= '0;
			o_switch <= 1'b0;
		end else if (i_switch != o_switch) begin
			// Follow the input on the last differing cycle
			if (stable_cnt == CNT_W'(`DEBOUNCE_LIMIT - 1)) begin
				o_switch <= i_switch;
				stable_cnt <= '0;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end else begin
			// Bounced back, start over
			stable_cnt <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/seg7_encode.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7_encode (
	input  logic              i_clk,
	input  disp_pkg::digit_t  i_digit,
	output disp_pkg::seg7_t   o_segments_n
);

	import disp_pkg::*;

	seg7_t seg_on;

	// Lit segments, G down to A
	always_comb begin
		case (i_digit)
			4'h0: seg_on = 7'b0111111;
			4'h1: seg_on = 7'b0000110;
			4'h2: seg_on = 7'b1011011;
			4'h3: seg_on = 7'b1001111;
			4'h4: seg_on = 7'b1100110;
			4'h5: seg_on = 7'b1101101;
			4'h6: seg_on = 7'b1111101;
			4'h7: seg_on = 7'b0000111;
			4'h8: seg_on = 7'b1111111;
			4'h9: seg_on = 7'b1101111;
			4'hA: seg_on = 7'b1110111;
			4'hB: seg_on = 7'b1111100;
			4'hC: seg_on = 7'b0111001;
			4'hD: seg_on = 7'b1011110;
			4'hE: seg_on = 7'b1111001;
			default: seg_on = 7'b1110001;
		endcase
	end

	// Board segments are active low
	always_ff @(posedge i_clk) begin
		o_segments_n <= ~seg_on;
	end

endmodule

`default_nettype wire

// ==== verilog/hnet_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hnet_top (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_switch_1,
	output disp_pkg::seg7_t    o_segment1_n,
	output disp_pkg::seg7_t    o_segment2_n,
	output logic               o_led_1,
	output logic               o_link_req,
	output logic               o_link_ack,
	output cellnet_pkg::addr_t o_link_addr,
	output cellnet_pkg::data_t o_link_data
);

	import cellnet_pkg::*;
	import disp_pkg::*;

	logic src_tick;
	logic snk_tick;

	// Link wires
	logic cn_req;
	logic cn_ack;
	addr_t cn_addr;
	data_t cn_data;
	data_t cn_o_data;
	logic cn_err;

	logic w_switch_1;
	logic r_switch_1;
	logic press;

	digit_t disp_1_digit;
	digit_t disp_2_digit;

	link_tick_gen i_link_tick_gen (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.o_src_tick(src_tick),
		.o_snk_tick(snk_tick)
	);

	cellnet_source i_cellnet_source (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_tick(src_tick),
		.i_ack(cn_ack),
		.o_req(cn_req),
		.o_addr(cn_addr),
		.o_dat(cn_data)
	);

	cellnet_sink i_cellnet_sink (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_tick(snk_tick),
		.i_req(cn_req),
		.i_addr(cn_addr),
		.i_dat(cn_data),
		.o_ack(cn_ack),
		.o_dat(cn_o_data),
		.o_err(cn_err)
	);

	debounce i_debounce (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_switch(i_switch_1),
		.o_switch(w_switch_1)
	);

	assign press = w_switch_1 & ~r_switch_1;

	// Snapshot link and sink data on each press
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_switch_1 <= 1'b0;
			disp_1_digit <= '0;
			disp_2_digit <= '0;
		end else begin
			r_switch_1 <= w_switch_1;
			if (press) begin
				disp_1_digit <= cn_data;
				disp_2_digit <= cn_o_data;
			end
		end
	end

	// Sticky until reset
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_led_1 <= 1'b0;
		end else if (cn_err) begin
			o_led_1 <= 1'b1;
		end
	end

	seg7_encode i_seg7_encode_1 (
		.i_clk(i_clk),
		.i_digit(disp_1_digit),
		.o_segments_n(o_segment1_n)
	);

	seg7_encode i_seg7_encode_2 (
		.i_clk(i_clk),
		.i_digit(disp_2_digit),
		.o_segments_n(o_segment2_n)
	);

	// Probe pins
	assign o_link_req = cn_req;
	assign o_link_ack = cn_ack;
	assign o_link_addr = cn_addr;
	assign o_link_data = cn_data;

endmodule

`default_nettype wire

// ==== testbench/hnet_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cellnet_consts.svh"

module hnet_tb;

	import cellnet_pkg::*;
	import disp_pkg::*;

	localparam int PRESSES = 40;
	localparam int MIN_CELLS = 64;
	localparam int PHASE_TIMEOUT = 40;
	localparam int CELL_TIMEOUT = 160;
	localparam int DRAIN_TIMEOUT = 20000;

	logic i_clk;
	logic i_reset;
	logic i_switch_1;
	seg7_t o_segment1_n;
	seg7_t o_segment2_n;
	logic o_led_1;
	logic o_link_req;
	logic o_link_ack;
	addr_t o_link_addr;
	data_t o_link_data;

	// Debounce and capture model
	logic m_switch;
	int m_diff_run;
	logic m_rise;
	data_t m_disp_1;
	data_t m_disp_2;

	// Link and sink model
	data_t m_sink_last;
	data_t m_sink_expected;
	logic m_led;
	int cells_done;
	int prev_phase;
	addr_t prev_addr;
	data_t prev_data;
	int phase_cycles;
	int cell_cycles;

	hnet_top i_hnet_top (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_switch_1(i_switch_1),
		.o_segment1_n(o_segment1_n),
		.o_segment2_n(o_segment2_n),
		.o_led_1(o_led_1),
		.o_link_req(o_link_req),
		.o_link_ack(o_link_ack),
		.o_link_addr(o_link_addr),
		.o_link_data(o_link_data)
	);

	always #2 i_clk = ~i_clk;

	// Letters a to g are bits 0 to 6
	function automatic seg7_t lit_segments(input digit_t digit);
		string lit;
		seg7_t bits;
		case (digit)
			4'h0: lit = "abcdef";
			4'h1: lit = "bc";
			4'h2: lit = "abdeg";
			4'h3: lit = "abcdg";
			4'h4: lit = "bcfg";
			4'h5: lit = "acdfg";
			4'h6: lit = "acdefg";
			4'h7: lit = "abc";
			4'h8: lit = "abcdefg";
			4'h9: lit = "abcdfg";
			4'hA: lit = "abcefg";
			4'hB: lit = "cdefg";
			4'hC: lit = "adef";
			4'hD: lit = "bcdeg";
			4'hE: lit = "adefg";
			default: lit = "aefg";
		endcase
		bits = '0;
		for (int i = 0; i < lit.len(); i++) begin
			bits = bits | seg7_t'(1 << (int'(lit[i]) - 97));
		end
		return bits;
	endfunction

	// Idle, req, req and ack, ack only
	function automatic int phase_of(input logic req, input logic ack);
		case ({req, ack})
			2'b00: return 0;
			2'b10: return 1;
			2'b11: return 2;
			default: return 3;
		endcase
	endfunction

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic stop_run(input string reason);
		$display("%s (time %0t)", reason, $time);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	// One clock: check outputs, advance the models, drive the next input
	task automatic step_cycle(input logic next_switch);
		int cur_phase;
		seg7_t exp_seg_1;
		seg7_t exp_seg_2;
		logic [7:0] cell_index;
		@(posedge i_clk);
		#1;
		exp_seg_1 = ~lit_segments(m_disp_1);
		exp_seg_2 = ~lit_segments(m_disp_2);
		check_value("o_segment1_n", 32'(exp_seg_1), 32'(o_segment1_n));
		check_value("o_segment2_n", 32'(exp_seg_2), 32'(o_segment2_n));
		check_value("o_led_1", 32'(m_led), 32'(o_led_1));

		// Capture edge follows the debounced rise
		if (m_rise) begin
			m_disp_1 = prev_data;
			m_disp_2 = m_sink_last;
		end

		m_rise = 1'b0;
		if (i_switch_1 != m_switch) begin
			m_diff_run++;
			if (m_diff_run == `DEBOUNCE_LIMIT) begin
				m_switch = i_switch_1;
				m_rise = i_switch_1;
				m_diff_run = 0;
			end
		end else begin
			m_diff_run = 0;
		end

		cur_phase = phase_of(o_link_req, o_link_ack);
		if (cur_phase != prev_phase) begin
			check_value("link handshake phase", (prev_phase + 1) % 4, cur_phase);
			phase_cycles = 0;
		end else begin
			phase_cycles++;
		end
		if (prev_phase != 0 || cur_phase != 0) begin
			check_value("o_link_addr", 32'(prev_addr), 32'(o_link_addr));
			check_value("o_link_data", 32'(prev_data), 32'(o_link_data));
		end
		if (prev_phase == 1 && cur_phase == 2 && o_link_addr == `SINK_ADDR) begin
			if (o_link_data != m_sink_expected) begin
				m_led = 1'b1;
			end
			m_sink_last = o_link_data;
			m_sink_expected = m_sink_expected + 4'd1;
		end
		if (prev_phase == 3 && cur_phase == 0) begin
			cell_index = 8'(cells_done);
			check_value("o_link_addr of cell", 32'(cell_index[3:0]), 32'(o_link_addr));
			check_value("o_link_data of cell", 32'(cell_index[7:4]), 32'(o_link_data));
			cells_done++;
			cell_cycles = 0;
		end else begin
			cell_cycles++;
		end
		if (phase_cycles > PHASE_TIMEOUT) begin
			stop_run($sformatf("Timeout: req and ack did not change for %0d cycles",
				PHASE_TIMEOUT));
		end
		if (cell_cycles > CELL_TIMEOUT) begin
			stop_run($sformatf("Timeout: no cell completed within %0d cycles",
				CELL_TIMEOUT));
		end
		prev_phase = cur_phase;
		prev_addr = o_link_addr;
		prev_data = o_link_data;

		i_switch_1 = next_switch;
	endtask

	task automatic hold_switch(input logic level, input int cycles);
		repeat (cycles) step_cycle(level);
	endtask

	// Glitch, real press with a glitch inside, then a long release
	task automatic press_button();
		int burst;
		burst = 1 + ($urandom % (`DEBOUNCE_LIMIT - 1));
		hold_switch(1'b1, burst);
		hold_switch(1'b0, 1 + ($urandom % 4));
		hold_switch(1'b1, `DEBOUNCE_LIMIT + 3 + ($urandom % 16));
		burst = 1 + ($urandom % (`DEBOUNCE_LIMIT - 1));
		hold_switch(1'b0, burst);
		hold_switch(1'b1, 3 + ($urandom % 6));
		hold_switch(1'b0, `DEBOUNCE_LIMIT + 2 + ($urandom % 16));
	endtask

	initial begin
		int seed_init;
		int drain_cycles;
		i_clk = 1'b0;
		i_reset = 1'b1;
		i_switch_1 = 1'b0;
		seed_init = $urandom(20848);

		m_switch = 1'b0;
		m_diff_run = 0;
		m_rise = 1'b0;
		m_disp_1 = '0;
		m_disp_2 = '0;
		m_sink_last = '0;
		m_sink_expected = '0;
		m_led = 1'b0;
		cells_done = 0;
		phase_cycles = 0;
		cell_cycles = 0;

		repeat (3) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		check_value("o_link_req", 0, 32'(o_link_req));
		check_value("o_link_ack", 0, 32'(o_link_ack));
		check_value("o_led_1", 0, 32'(o_led_1));
		prev_phase = phase_of(o_link_req, o_link_ack);
		prev_addr = o_link_addr;
		prev_data = o_link_data;

		repeat (PRESSES) press_button();

		drain_cycles = 0;
		while (cells_done < MIN_CELLS) begin
			if (drain_cycles >= DRAIN_TIMEOUT) begin
				stop_run($sformatf("Timeout: only %0d of %0d cells completed",
					cells_done, MIN_CELLS));
			end else begin
				step_cycle(1'b0);
				drain_cycles++;
			end
		end

		check_value("o_led_1", 0, 32'(o_led_1));
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/cellnet_pkg.sv
common/disp_pkg.sv
cellnet/cellnet_source.sv
cellnet/cellnet_sink.sv
verilog/link_tick_gen.sv
verilog/debounce.sv
verilog/seg7_encode.sv
verilog/hnet_top.sv
testbench/hnet_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module hnet_tb -Mdir obj_dir -o hnet_sim -f src.f

# Show the simulation output and pass only on the pass line
./obj_dir/hnet_sim | tee /dev/stderr | grep -x "TEST OK" > /dev/null
echo "simulation passed"
